//--- Bender.yml
package:
  name: datapath

sources:
  - source/cpu_types_pkg.sv
  - source/control_unit.sv
  - source/register_file.sv
  - source/alu.sv
  - source/request_unit.sv
  - source/pc_unit.sv
  - source/datapath.sv
  - target: test
    files:
      - bench/datapath_chk.sv
      - bench/datapath_tb.sv

//--- bench/datapath_chk.sv
// Bound checks on the memory handshake and the halt latch
// Failure count read back by the testbench
`timescale 1ns/1ps
`default_nettype none

module datapath_chk (
  input logic                      CLK,
  input logic                      nRST,
  input cpu_types_pkg::cache_rsp_t rsp,
  input cpu_types_pkg::dp_req_t    req
);
  import cpu_types_pkg::*;

  int fail_count = 0;

  // Pending request frozen until dhit
  assert property (@(posedge CLK) disable iff (!nRST)
    (req.dmem_ren || req.dmem_wen) && !rsp.dhit |=>
      $stable(req.dmem_addr) && $stable(req.dmem_store) &&
      $stable(req.dmem_ren) && $stable(req.dmem_wen))
    else begin
      $error("data request changed before dhit");
      fail_count++;
    end

  // Sticky halt
  assert property (@(posedge CLK) disable iff (!nRST) req.halt |=> req.halt)
    else begin
      $error("halt dropped");
      fail_count++;
    end

  assert property (@(posedge CLK) disable iff (!nRST) !(req.dmem_ren && req.dmem_wen))
    else begin
      $error("read and write requested together");
      fail_count++;
    end

  // No fetch and a frozen PC while halted
  assert property (@(posedge CLK) disable iff (!nRST)
    req.halt |=> !req.imem_ren && $stable(req.imem_addr))
    else begin
      $error("fetch or PC change while halted");
      fail_count++;
    end

endmodule

bind datapath datapath_chk chk0 (.CLK(CLK), .nRST(nRST), .rsp(rsp), .req(req));

`default_nettype wire

//--- bench/datapath_tb.sv
// Directed testbench for the single-cycle datapath
// Instruction and data memory models with LFSR hit latency,
// program builders, compare tasks and closing status
`timescale 1ns/1ps
`default_nettype none

module datapath_tb;
  import cpu_types_pkg::*;

  localparam word_t PC_INIT = 32'h0000_0000;

  logic       CLK;
  logic       nRST;
  cache_rsp_t rsp;
  dp_req_t    req;

  word_t imem [64];
  word_t dmem [64];
  // Observed fetches and stores, and their expected values
  word_t fetch_q[$];
  word_t st_addr_q[$];
  word_t st_data_q[$];
  word_t exp_fetch_q[$];
  word_t exp_addr_q[$];
  word_t exp_data_q[$];
  int    emit_idx;
  int    st_off;
  int    lat;
  int    errors;
  int    timeouts;
  logic [31:0] lfsr_state = 32'd32;

  datapath #(.PC_INIT(PC_INIT)) dut0 (.CLK(CLK), .nRST(nRST), .rsp(rsp), .req(req));

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_state[0]};
      if (lfsr_state[0]) lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
      else lfsr_state = lfsr_state >> 1;
    end
    return r;
  endfunction

  // Instruction encoders
  function automatic word_t rtype(input funct_t f, input regbits_t rs, input regbits_t rt,
                                  input regbits_t rd, input logic [4:0] sh);
    return {RTYPE, rs, rt, rd, sh, f};
  endfunction

  function automatic word_t itype(input opcode_t op, input regbits_t rs, input regbits_t rt,
                                  input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic word_t jtype(input opcode_t op, input logic [25:0] t);
    return {op, t};
  endfunction

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_req(input string name, input dp_req_t got, input dp_req_t exp);
    // Address and store data carry no meaning without a request
    got.dmem_addr  = '0;
    got.dmem_store = '0;
    exp.dmem_addr  = '0;
    exp.dmem_store = '0;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // Memory model with data requests served first and one idle cycle after each hit
  always @(posedge CLK) begin
    if (!nRST) begin
      rsp.ihit <= 1'b0;
      rsp.dhit <= 1'b0;
      lat = 0;
    end else if (rsp.ihit || rsp.dhit) begin
      rsp.ihit <= 1'b0;
      rsp.dhit <= 1'b0;
    end else if (req.dmem_ren || req.dmem_wen) begin
      if (lat > 0) lat--;
      else begin
        // PC must still point at the memory instruction
        check_word("imem_addr", req.imem_addr, fetch_q[$]);
        rsp.dhit      <= 1'b1;
        rsp.dmem_load <= dmem[req.dmem_addr[7:2]];
        if (req.dmem_wen) begin
          dmem[req.dmem_addr[7:2]] = req.dmem_store;
          st_addr_q.push_back(req.dmem_addr);
          st_data_q.push_back(req.dmem_store);
        end
        lat = rand_bits(2);
      end
    end else if (req.imem_ren) begin
      if (lat > 0) lat--;
      else begin
        rsp.ihit      <= 1'b1;
        rsp.imem_load <= imem[req.imem_addr[7:2]];
        fetch_q.push_back(req.imem_addr);
        lat = rand_bits(2);
      end
    end
  end

  task automatic start_program();
    // Unused slots halt a runaway fetch, slot index in the spare bits
    for (int i = 0; i < 64; i++) begin
      imem[i] = jtype(HALT, 26'(i));
      dmem[i] = 32'hD000_0000 | (i << 2);
    end
    emit_idx = 0;
    st_off   = 0;
    fetch_q.delete();
    st_addr_q.delete();
    st_data_q.delete();
    exp_fetch_q.delete();
    exp_addr_q.delete();
    exp_data_q.delete();
  endtask

  task automatic emit(input word_t w);
    imem[emit_idx] = w;
    emit_idx++;
  endtask

  task automatic expect_store(input word_t addr, input word_t data);
    exp_addr_q.push_back(addr);
    exp_data_q.push_back(data);
  endtask

  // Result into rd and then stored to the next free slot
  task automatic alu_case(input word_t w, input regbits_t rd, input word_t exp);
    emit(w);
    emit(itype(SW, 5'd0, rd, st_off[15:0]));
    expect_store(st_off, exp);
    st_off += 4;
  endtask

  task automatic apply_reset();
    @(posedge CLK);
    nRST <= 1'b0;
    repeat (16) @(posedge CLK);
    nRST <= 1'b1;
    @(posedge CLK);
  endtask

  // Wait for halt, then compare stores, fetches and the halted state
  task automatic check_results();
    int    n;
    word_t held;
    n = 0;
    while (!req.halt && n < 4000) begin
      @(posedge CLK);
      n++;
    end
    if (!req.halt) begin
      timeouts++;
      $display("Timeout: halt never rose at %0t", $time);
    end
    check_word("store count", st_addr_q.size(), exp_addr_q.size());
    for (int i = 0; i < exp_addr_q.size() && i < st_addr_q.size(); i++) begin
      check_word("dmem_addr", st_addr_q[i], exp_addr_q[i]);
      check_word("dmem_store", st_data_q[i], exp_data_q[i]);
    end
    if (exp_fetch_q.size() > 0) begin
      check_word("fetch count", fetch_q.size(), exp_fetch_q.size());
      for (int i = 0; i < exp_fetch_q.size() && i < fetch_q.size(); i++)
        check_word("imem_addr", fetch_q[i], exp_fetch_q[i]);
    end
    // PC sits just past HALT once halted
    check_flag("imem_ren", req.imem_ren, 1'b0);
    held = fetch_q[$] + 32'd4;
    repeat (20) begin
      @(posedge CLK);
      check_flag("halt", req.halt, 1'b1);
      check_word("imem_addr", req.imem_addr, held);
    end
  endtask

  task automatic run_program();
    apply_reset();
    check_results();
  endtask

  task automatic test_reset();
    dp_req_t exp;
    start_program();
    apply_reset();
    exp           = '0;
    exp.imem_ren  = 1'b1;
    exp.imem_addr = PC_INIT;
    check_req("req", req, exp);
    exp_fetch_q.push_back(PC_INIT);
    check_results();
  endtask

  task automatic test_alu();
    word_t       a;
    word_t       b;
    word_t       sx;
    logic [15:0] k;
    logic [4:0]  sh;
    a  = rand_bits(32);
    b  = rand_bits(32);
    k  = 16'(rand_bits(16));
    sh = 5'(rand_bits(5));
    sx = {{16{k[15]}}, k};
    start_program();
    emit(itype(LUI, 5'd0, 5'd1, a[31:16]));
    emit(itype(ORI, 5'd1, 5'd1, a[15:0]));
    emit(itype(LUI, 5'd0, 5'd2, b[31:16]));
    emit(itype(ORI, 5'd2, 5'd2, b[15:0]));
    alu_case(rtype(ADDU, 5'd1, 5'd2, 5'd3, 5'd0), 5'd3, a + b);
    alu_case(rtype(SUBU, 5'd1, 5'd2, 5'd3, 5'd0), 5'd3, a - b);
    alu_case(rtype(AND, 5'd1, 5'd2, 5'd3, 5'd0), 5'd3, a & b);
    alu_case(rtype(OR, 5'd1, 5'd2, 5'd3, 5'd0), 5'd3, a | b);
    alu_case(rtype(XOR, 5'd1, 5'd2, 5'd3, 5'd0), 5'd3, a ^ b);
    alu_case(rtype(NOR, 5'd1, 5'd2, 5'd3, 5'd0), 5'd3, ~(a | b));
    alu_case(rtype(SLT, 5'd1, 5'd2, 5'd3, 5'd0), 5'd3, word_t'($signed(a) < $signed(b)));
    alu_case(rtype(SLTU, 5'd1, 5'd2, 5'd3, 5'd0), 5'd3, word_t'(a < b));
    alu_case(rtype(SLL, 5'd0, 5'd2, 5'd3, sh), 5'd3, b << sh);
    alu_case(rtype(SRL, 5'd0, 5'd2, 5'd3, sh), 5'd3, b >> sh);
    alu_case(itype(ADDIU, 5'd1, 5'd3, k), 5'd3, a + sx);
    alu_case(itype(SLTI, 5'd1, 5'd3, k), 5'd3, word_t'($signed(a) < $signed(sx)));
    alu_case(itype(SLTIU, 5'd1, 5'd3, k), 5'd3, word_t'(a < sx));
    alu_case(itype(ANDI, 5'd1, 5'd3, k), 5'd3, a & {16'h0000, k});
    alu_case(itype(ORI, 5'd1, 5'd3, k), 5'd3, a | {16'h0000, k});
    alu_case(itype(XORI, 5'd1, 5'd3, k), 5'd3, a ^ {16'h0000, k});
    alu_case(itype(LUI, 5'd0, 5'd3, k), 5'd3, {k, 16'h0000});
    // r0 ignores the write
    alu_case(rtype(ADDU, 5'd1, 5'd2, 5'd0, 5'd0), 5'd0, 32'h0);
    emit(jtype(HALT, '0));
    run_program();
  endtask

  task automatic test_mem();
    word_t a;
    word_t b;
    a = rand_bits(32);
    b = rand_bits(32);
    start_program();
    emit(itype(LUI, 5'd0, 5'd1, a[31:16]));
    emit(itype(ORI, 5'd1, 5'd1, a[15:0]));
    emit(itype(LUI, 5'd0, 5'd2, b[31:16]));
    emit(itype(ORI, 5'd2, 5'd2, b[15:0]));
    emit(itype(SW, 5'd0, 5'd1, 16'h0040));
    emit(itype(SW, 5'd0, 5'd2, 16'h0044));
    emit(itype(LW, 5'd0, 5'd4, 16'h0040));
    emit(itype(LW, 5'd0, 5'd5, 16'h0044));
    emit(itype(SW, 5'd0, 5'd4, 16'h0048));
    emit(itype(SW, 5'd0, 5'd5, 16'h004C));
    emit(jtype(HALT, '0));
    expect_store(32'h40, a);
    expect_store(32'h44, b);
    expect_store(32'h48, a);
    expect_store(32'h4C, b);
    run_program();
  endtask

  task automatic test_branch();
    start_program();
    emit(itype(ORI, 5'd0, 5'd1, 16'd5));
    emit(itype(ORI, 5'd0, 5'd2, 16'd5));
    emit(itype(BEQ, 5'd1, 5'd2, 16'd1));
    emit(itype(ORI, 5'd0, 5'd3, 16'd1));
    emit(itype(BNE, 5'd1, 5'd2, 16'd5));
    emit(itype(BEQ, 5'd1, 5'd0, 16'd5));
    emit(itype(BNE, 5'd1, 5'd0, 16'd1));
    emit(itype(ORI, 5'd0, 5'd3, 16'd2));
    emit(itype(SW, 5'd0, 5'd3, 16'd0));
    emit(jtype(HALT, '0));
    // Taken branches go to pc + 4 + (imm << 2)
    exp_fetch_q = '{0, 4, 8, 8 + 4 + (1 << 2), 20, 24, 24 + 4 + (1 << 2), 36};
    expect_store(32'h0, 32'h0);
    run_program();
  endtask

  task automatic test_jump();
    start_program();
    emit(jtype(JAL, 26'd4));
    emit_idx = 4;
    emit(itype(ORI, 5'd0, 5'd5, 16'd28));
    emit(rtype(JR, 5'd5, 5'd0, 5'd0, 5'd0));
    emit_idx = 7;
    emit(jtype(J, 26'd10));
    emit_idx = 10;
    emit(itype(SW, 5'd0, 5'd31, 16'd0));
    emit(jtype(HALT, '0));
    exp_fetch_q = '{0, 4 << 2, 20, 28, 10 << 2, 44};
    // JAL links PC plus 4
    expect_store(32'h0, 32'h4);
    run_program();
  endtask

  initial begin
    rsp      = '0;
    nRST     = 1'b0;
    errors   = 0;
    timeouts = 0;
    test_reset();
    test_alu();
    test_mem();
    test_branch();
    test_jump();
    $display("errors=%0d timeouts=%0d assertion_failures=%0d",
             errors, timeouts, dut0.chk0.fail_count);
    if (errors == 0 && timeouts == 0 && dut0.chk0.fail_count == 0) $display("STATUS: PASS");
    else $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- datapath.f
source/cpu_types_pkg.sv
source/control_unit.sv
source/register_file.sv
source/alu.sv
source/request_unit.sv
source/pc_unit.sv
source/datapath.sv
bench/datapath_chk.sv
bench/datapath_tb.sv

//--- source/alu.sv
// Execute stage
// Add, subtract, logic, shifts, set-less-than, upper immediate
// Zero flag taken from the result
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  cpu_types_pkg::aluop_t alu_op,
  input  cpu_types_pkg::word_t  port_a,
  input  cpu_types_pkg::word_t  port_b,
  output cpu_types_pkg::word_t  port_o,
  output logic                  zero
);
  import cpu_types_pkg::*;

  always_comb begin
    case (alu_op)
      // Shift amount rides in port_a
      ALU_SLL:  port_o = port_b << port_a[4:0];
      ALU_SRL:  port_o = port_b >> port_a[4:0];
      ALU_ADD:  port_o = port_a + port_b;
      ALU_SUB:  port_o = port_a - port_b;
      ALU_AND:  port_o = port_a & port_b;
      ALU_OR:   port_o = port_a | port_b;
      ALU_XOR:  port_o = port_a ^ port_b;
      ALU_NOR:  port_o = ~(port_a | port_b);
      ALU_SLT:  port_o = {31'b0, $signed(port_a) < $signed(port_b)};
      ALU_SLTU: port_o = {31'b0, port_a < port_b};
      // Low half of the immediate to the top
      ALU_LUI:  port_o = {port_b[15:0], 16'h0000};
      default:  port_o = '0;
    endcase
  end

  // Equality for branches
  assign zero = (port_o == '0);

endmodule

`default_nettype wire

//--- source/control_unit.sv
// Decode stage
// Opcode and funct to control word, unknown encodings become no-ops
`timescale 1ns/1ps
`default_nettype none

module control_unit (
  input  cpu_types_pkg::instr_u instr,
  output cpu_types_pkg::ctrl_t  ctrl
);
  import cpu_types_pkg::*;

  always_comb begin
    // No-op baseline, sequential PC and no writes
    ctrl        = '0;
    ctrl.alu_op = ALU_ADD;
    ctrl.mem_to_reg = WB_ALU;
    ctrl.jump   = JMP_SEQ;
    case (instr.r_t.opcode)
      RTYPE: begin
        ctrl.reg_dst   = 1'b1;
        ctrl.reg_write = 1'b1;
        case (instr.r_t.funct)
          SLL:  begin ctrl.alu_op = ALU_SLL; ctrl.use_shamt = 1'b1; end
          SRL:  begin ctrl.alu_op = ALU_SRL; ctrl.use_shamt = 1'b1; end
          ADDU: ctrl.alu_op = ALU_ADD;
          SUBU: ctrl.alu_op = ALU_SUB;
          AND:  ctrl.alu_op = ALU_AND;
          OR:   ctrl.alu_op = ALU_OR;
          XOR:  ctrl.alu_op = ALU_XOR;
          NOR:  ctrl.alu_op = ALU_NOR;
          SLT:  ctrl.alu_op = ALU_SLT;
          SLTU: ctrl.alu_op = ALU_SLTU;
          JR: begin
            // Register jump, nothing written back
            ctrl.reg_write = 1'b0;
            ctrl.jump      = JMP_REG;
          end
          default: ctrl.reg_write = 1'b0;
        endcase
      end
      // Immediate ALU ops write rt
      ADDIU: begin ctrl.alu_src = 1'b1; ctrl.ext_signed = 1'b1; ctrl.reg_write = 1'b1; end
      SLTI: begin
        ctrl.alu_op = ALU_SLT;
        ctrl.alu_src = 1'b1; ctrl.ext_signed = 1'b1; ctrl.reg_write = 1'b1;
      end
      SLTIU: begin
        ctrl.alu_op = ALU_SLTU;
        ctrl.alu_src = 1'b1; ctrl.ext_signed = 1'b1; ctrl.reg_write = 1'b1;
      end
      // Logic immediates are zero extended
      ANDI: begin ctrl.alu_op = ALU_AND; ctrl.alu_src = 1'b1; ctrl.reg_write = 1'b1; end
      ORI:  begin ctrl.alu_op = ALU_OR;  ctrl.alu_src = 1'b1; ctrl.reg_write = 1'b1; end
      XORI: begin ctrl.alu_op = ALU_XOR; ctrl.alu_src = 1'b1; ctrl.reg_write = 1'b1; end
      LUI:  begin ctrl.alu_op = ALU_LUI; ctrl.alu_src = 1'b1; ctrl.reg_write = 1'b1; end
      LW: begin
        ctrl.alu_src = 1'b1; ctrl.ext_signed = 1'b1;
        ctrl.mem_read = 1'b1; ctrl.reg_write = 1'b1;
        ctrl.mem_to_reg = WB_MEM;
      end
      SW: begin ctrl.alu_src = 1'b1; ctrl.ext_signed = 1'b1; ctrl.mem_write = 1'b1; end
      // Compare by subtraction, zero flag decides
      BEQ: begin ctrl.alu_op = ALU_SUB; ctrl.ext_signed = 1'b1; ctrl.branch = 1'b1; end
      BNE: begin
        ctrl.alu_op = ALU_SUB; ctrl.ext_signed = 1'b1;
        ctrl.branch = 1'b1; ctrl.branch_ne = 1'b1;
      end
      J:   ctrl.jump = JMP_TARGET;
      JAL: begin
        // Link into r31
        ctrl.jump = JMP_TARGET; ctrl.reg_write = 1'b1; ctrl.mem_to_reg = WB_PC4;
      end
      HALT: ctrl.halt = 1'b1;
      default: ;
    endcase
  end

endmodule

`default_nettype wire

//--- source/cpu_types_pkg.sv
// Shared types for the single-cycle MIPS subset
// Opcode, funct and ALU-op encodings, instruction word views,
// control word, cache request and response bundles
`default_nettype none

package cpu_types_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  regbits_t;

  // Primary opcodes
  typedef enum logic [5:0] {
    RTYPE = 6'b000000,
    J     = 6'b000010,
    JAL   = 6'b000011,
    BEQ   = 6'b000100,
    BNE   = 6'b000101,
    ADDIU = 6'b001001,
    SLTI  = 6'b001010,
    SLTIU = 6'b001011,
    ANDI  = 6'b001100,
    ORI   = 6'b001101,
    XORI  = 6'b001110,
    LUI   = 6'b001111,
    LW    = 6'b100011,
    SW    = 6'b101011,
    HALT  = 6'b111111
  } opcode_t;

  // R-type function codes
  typedef enum logic [5:0] {
    SLL  = 6'b000000,
    SRL  = 6'b000010,
    JR   = 6'b001000,
    ADDU = 6'b100001,
    SUBU = 6'b100011,
    AND  = 6'b100100,
    OR   = 6'b100101,
    XOR  = 6'b100110,
    NOR  = 6'b100111,
    SLT  = 6'b101010,
    SLTU = 6'b101011
  } funct_t;

  typedef enum logic [3:0] {
    ALU_SLL, ALU_SRL, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
    ALU_XOR, ALU_NOR, ALU_SLT, ALU_SLTU, ALU_LUI
  } aluop_t;

  // Write-back source and next-PC source
  typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4} wbsel_t;
  typedef enum logic [1:0] {JMP_SEQ, JMP_TARGET, JMP_REG} jmpsel_t;

  typedef struct packed {
    opcode_t    opcode;
    regbits_t   rs;
    regbits_t   rt;
    regbits_t   rd;
    logic [4:0] shamt;
    funct_t     funct;
  } r_t;

  typedef struct packed {
    opcode_t     opcode;
    regbits_t    rs;
    regbits_t    rt;
    logic [15:0] imm;
  } i_t;

  typedef struct packed {
    opcode_t     opcode;
    logic [25:0] target;
  } j_t;

  // One fetched word, three decodings
  typedef union packed {
    r_t r_t;
    i_t i_t;
    j_t j_t;
  } instr_u;

  typedef struct packed {
    aluop_t  alu_op;
    logic    alu_src;
    logic    ext_signed;
    logic    reg_dst;
    logic    reg_write;
    wbsel_t  mem_to_reg;
    logic    mem_read;
    logic    mem_write;
    logic    branch;
    logic    branch_ne;
    jmpsel_t jump;
    logic    use_shamt;
    logic    halt;
  } ctrl_t;

  // Datapath to caches
  typedef struct packed {
    logic  imem_ren;
    word_t imem_addr;
    logic  dmem_ren;
    logic  dmem_wen;
    word_t dmem_addr;
    word_t dmem_store;
    logic  halt;
  } dp_req_t;

  // Caches to datapath
  typedef struct packed {
    logic  ihit;
    logic  dhit;
    word_t imem_load;
    word_t dmem_load;
  } cache_rsp_t;

endpackage

`default_nettype wire

//--- source/datapath.sv
// Single-cycle datapath top
// Decode, register file, ALU, data request and PC units
// Immediate extension, destination and write-back muxing,
// commit strobe and halt latch
`timescale 1ns/1ps
`default_nettype none

module datapath #(
  parameter cpu_types_pkg::word_t PC_INIT = '0
) (
  input  logic                      CLK,
  input  logic                      nRST,
  input  cpu_types_pkg::cache_rsp_t rsp,
  output cpu_types_pkg::dp_req_t    req
);
  import cpu_types_pkg::*;

  instr_u   instr;
  word_t    instr_q;
  ctrl_t    ctrl;
  word_t    imm_ext, rdat1, rdat2, port_a, port_b, port_o;
  word_t    wdat, pc, pc_plus4;
  regbits_t wsel;
  logic     zero, commit, halt_q;
  logic     dmem_ren, dmem_wen, mem_op;

  // Fetched word kept for loads and stores waiting on dhit
  always_ff @(posedge CLK) begin
    if (rsp.ihit) instr_q <= rsp.imem_load;
  end
  assign instr = rsp.ihit ? rsp.imem_load : instr_q;

  control_unit u_ctrl (.instr(instr), .ctrl(ctrl));

  // Sign or zero extension of the 16-bit immediate
  assign imm_ext = ctrl.ext_signed ? {{16{instr.i_t.imm[15]}}, instr.i_t.imm}
                                   : {16'h0000, instr.i_t.imm};

  // JAL links to r31, R-type to rd, the rest to rt
  always_comb begin
    if (ctrl.mem_to_reg == WB_PC4) wsel = 5'd31;
    else if (ctrl.reg_dst)         wsel = instr.r_t.rd;
    else                           wsel = instr.r_t.rt;
  end

  always_comb begin
    case (ctrl.mem_to_reg)
      WB_MEM:  wdat = rsp.dmem_load;
      WB_PC4:  wdat = pc_plus4;
      default: wdat = port_o;
    endcase
  end

  // Non-memory ops commit on ihit, loads and stores on dhit
  assign mem_op = ctrl.mem_read || ctrl.mem_write;
  assign commit = !halt_q && ((rsp.ihit && !mem_op) || (rsp.dhit && (dmem_ren || dmem_wen)));

  register_file u_rf (
    .CLK(CLK), .nRST(nRST), .wen(ctrl.reg_write && commit), .wsel(wsel), .wdat(wdat),
    .rsel1(instr.r_t.rs), .rsel2(instr.r_t.rt), .rdat1(rdat1), .rdat2(rdat2)
  );

  // Shift amount replaces rs for SLL and SRL
  assign port_a = ctrl.use_shamt ? {27'b0, instr.r_t.shamt} : rdat1;
  assign port_b = ctrl.alu_src ? imm_ext : rdat2;

  alu u_alu (
    .alu_op(ctrl.alu_op), .port_a(port_a), .port_b(port_b), .port_o(port_o), .zero(zero)
  );

  request_unit u_req (
    .CLK(CLK), .nRST(nRST), .ihit(rsp.ihit), .dhit(rsp.dhit),
    .mem_read(ctrl.mem_read), .mem_write(ctrl.mem_write), .addr(port_o), .store(rdat2),
    .dmem_ren(dmem_ren), .dmem_wen(dmem_wen),
    .dmem_addr(req.dmem_addr), .dmem_store(req.dmem_store)
  );

  pc_unit #(.PC_INIT(PC_INIT)) u_pc (
    .CLK(CLK), .nRST(nRST), .commit(commit), .ctrl(ctrl), .zero(zero),
    .imm_ext(imm_ext), .target(instr.j_t.target), .rs_val(rdat1),
    .pc(pc), .pc_plus4(pc_plus4)
  );

  // Sticky halt until reset
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) halt_q <= 1'b0;
    else if (commit && ctrl.halt) halt_q <= 1'b1;
  end

  assign req.imem_ren  = !halt_q;
  assign req.imem_addr = pc;
  assign req.dmem_ren  = dmem_ren;
  assign req.dmem_wen  = dmem_wen;
  assign req.halt      = halt_q;

endmodule

`default_nettype wire

//--- source/pc_unit.sv
// Result stage
// Program counter with branch, jump and register-jump selection
`timescale 1ns/1ps
`default_nettype none

module pc_unit #(
  parameter cpu_types_pkg::word_t PC_INIT = '0
) (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  commit,
  input  cpu_types_pkg::ctrl_t  ctrl,
  input  logic                  zero,
  input  cpu_types_pkg::word_t  imm_ext,
  input  logic [25:0]           target,
  input  cpu_types_pkg::word_t  rs_val,
  output cpu_types_pkg::word_t  pc,
  output cpu_types_pkg::word_t  pc_plus4
);
  import cpu_types_pkg::*;

  word_t pc_next;
  logic  taken;

  assign pc_plus4 = pc + 32'd4;
  // BEQ wants equal, BNE wants not equal
  assign taken    = ctrl.branch && (zero != ctrl.branch_ne);

  always_comb begin
    case (ctrl.jump)
      JMP_TARGET: pc_next = {pc[31:28], target, 2'b00};
      JMP_REG:    pc_next = rs_val;
      default:    pc_next = taken ? pc_plus4 + (imm_ext << 2) : pc_plus4;
    endcase
  end

  // Advance only when the instruction commits
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) pc <= PC_INIT;
    else if (commit) pc <= pc_next;
  end

endmodule

`default_nettype wire

//--- source/register_file.sv
// 32 x 32 register file
// Two combinational read ports, one write port, r0 hardwired to zero
`timescale 1ns/1ps
`default_nettype none

module register_file (
  input  logic                    CLK,
  input  logic                    nRST,
  input  logic                    wen,
  input  cpu_types_pkg::regbits_t wsel,
  input  cpu_types_pkg::word_t    wdat,
  input  cpu_types_pkg::regbits_t rsel1,
  input  cpu_types_pkg::regbits_t rsel2,
  output cpu_types_pkg::word_t    rdat1,
  output cpu_types_pkg::word_t    rdat2
);
  import cpu_types_pkg::*;

  word_t regs [32];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (wsel != '0)) begin
      // r0 never takes a write
      regs[wsel] <= wdat;
    end
  end

  // Reads see the current contents
  assign rdat1 = regs[rsel1];
  assign rdat2 = regs[rsel2];

endmodule

`default_nettype wire

//--- source/request_unit.sv
// Data-memory request holder
// Raised the cycle after ihit of a load or store, dropped after dhit
`timescale 1ns/1ps
`default_nettype none

module request_unit (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 ihit,
  input  logic                 dhit,
  input  logic                 mem_read,
  input  logic                 mem_write,
  input  cpu_types_pkg::word_t addr,
  input  cpu_types_pkg::word_t store,
  output logic                 dmem_ren,
  output logic                 dmem_wen,
  output cpu_types_pkg::word_t dmem_addr,
  output cpu_types_pkg::word_t dmem_store
);
  import cpu_types_pkg::*;

  // Request flags
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      dmem_ren <= 1'b0;
      dmem_wen <= 1'b0;
    end else if (dhit) begin
      dmem_ren <= 1'b0;
      dmem_wen <= 1'b0;
    end else if (ihit) begin
      dmem_ren <= mem_read;
      dmem_wen <= mem_write;
    end
  end

  // Address and store data frozen from the fetch cycle
  always_ff @(posedge CLK) begin
    if (ihit && (mem_read || mem_write)) begin
      dmem_addr  <= addr;
      dmem_store <= store;
    end
  end

endmodule

`default_nettype wire
